// ==== Bender.yml ====
package:
  name: ahb_memory_slave

sources:
  - verilog/ahb_pkg.sv
  - verilog/mem_pkg.sv
  - verilog/ahb_addr_stage.sv
  - verilog/ahb_mem_array.sv
  - verilog/ahb_resp_stage.sv
  - verilog/ahb_memory_slave.sv
  - target: test
    files:
      - tb/ahb_memory_slave_checker.sv
      - tb/ahb_memory_slave_tb.sv

// ==== ahb_memory_slave.f ====
verilog/ahb_pkg.sv
verilog/mem_pkg.sv
verilog/ahb_addr_stage.sv
verilog/ahb_mem_array.sv
verilog/ahb_resp_stage.sv
verilog/ahb_memory_slave.sv
tb/ahb_memory_slave_checker.sv
tb/ahb_memory_slave_tb.sv

// ==== tb/ahb_memory_slave_checker.sv ====
// Checker with shadow memory, response prediction and one report line per test for the AHB slave
`timescale 1ns/100ps

module ahb_memory_slave_checker (
  input  logic                        hclk,
  input  logic                        rst_n,
  input  logic                        hsel,
  input  logic [ahb_pkg::HADDR_W-1:0] haddr,
  input  logic [1:0]                  htrans,
  input  logic                        hwrite,
  input  logic [2:0]                  hsize,
  input  logic [ahb_pkg::HDATA_W-1:0] hwdata,
  input  logic                        hready_in,
  input  logic [ahb_pkg::HDATA_W-1:0] hrdata,
  input  logic                        hready_out,
  input  logic [1:0]                  hresp,
  input  logic [8*24-1:0]             row_name,
  input  logic [1:0]                  row_resp,
  input  logic                        row_done,
  output int                          passes,
  output int                          fails
);

  import ahb_pkg::*;
  import mem_pkg::*;

  logic [31:0] shadow [MEM_WORDS];
  // Data phase in flight
  logic        pend;
  logic        pend_wr;
  logic        pend_ok;
  logic        err_first;
  logic [31:0] pend_addr;
  logic [2:0]  pend_size;
  // First mismatch of the running test
  logic        row_bad;
  logic [31:0] exp_v;
  logic [31:0] act_v;

  // Legal is at most a word, aligned to its size, inside the array
  function automatic logic transfer_legal(input logic [31:0] addr, input logic [2:0] size);
    return (size <= 3'd2) && (addr % (32'd1 << size) == 0) && ((addr >> 2) < MEM_WORDS);
  endfunction

  task automatic check(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp && !row_bad)
    begin
      exp_v   = exp;
      act_v   = act;
      row_bad = 1'b1;
    end
  endtask

  // Byte b changes when it lies between the offset and offset plus size
  task automatic shadow_write(input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] data);
    for (int b = 0; b < 4; b++)
      if (b >= addr[1:0] && b < addr[1:0] + (1 << size))
        shadow[addr >> 2][8*b +: 8] = data[8*b +: 8];
  endtask

  initial
  begin
    for (int w = 0; w < MEM_WORDS; w++)
      shadow[w] = '0;
    pend    = 1'b0;
    row_bad = 1'b0;
    passes  = 0;
    fails   = 0;
  end

  // ----------------------------------------
  // Data phase checks, then address capture
  // ----------------------------------------
  always @(posedge hclk)
  begin
    if (rst_n && pend)
    begin
      // ERROR stalls in its first cycle only
      check(!err_first, hready_out);
      check(pend_ok ? HRESP_OKAY : HRESP_ERROR, hresp);
      if (!err_first)
      begin
        check(row_resp, hresp);
        if (pend_ok && pend_wr && hresp === HRESP_OKAY)
          shadow_write(pend_addr, pend_size, hwdata);
        if (pend_ok && !pend_wr)
          check(shadow[pend_addr >> 2], hrdata);
        pend = 1'b0;
      end
      err_first = 1'b0;
    end
    else if (rst_n)
    begin
      // Quiet bus gives ready and OKAY
      check(1'b1, hready_out);
      check(HRESP_OKAY, hresp);
    end
    if (rst_n && hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ) && hready_in
        && hready_out)
    begin
      pend      = 1'b1;
      pend_wr   = hwrite;
      pend_addr = haddr;
      pend_size = hsize;
      pend_ok   = transfer_legal(haddr, hsize);
      err_first = !pend_ok;
    end
    if (row_done)
    begin
      if (row_bad)
        $display("ERR %0s: expected %h, actual %h", row_name, exp_v, act_v);
      else
        $display("PASS %0s", row_name);
      fails   = fails + row_bad;
      passes  = passes + !row_bad;
      row_bad = 1'b0;
    end
  end

endmodule

// ==== tb/ahb_memory_slave_tb.sv ====
// Testbench top with clock, reset, stimulus table and drive loop for the AHB memory slave
`timescale 1ns/100ps

module ahb_memory_slave_tb;

  import ahb_pkg::*;

  localparam int ROWS = 15;

  logic               hclk;
  logic               rst_n;
  logic               hsel;
  logic [HADDR_W-1:0] haddr;
  logic [1:0]         htrans;
  logic               hwrite;
  logic [2:0]         hsize;
  logic [HDATA_W-1:0] hwdata;
  logic               hready_in;
  logic [HDATA_W-1:0] hrdata;
  logic               hready_out;
  logic [1:0]         hresp;
  logic [8*24-1:0]    row_name;
  logic [1:0]         row_resp;
  logic               row_done;
  int                 passes;
  int                 fails;
  integer             seed;
  int                 n;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  logic [8*24-1:0]    t_name [ROWS];
  int                 t_kind [ROWS];
  logic [31:0]        t_addr [ROWS];
  logic [2:0]         t_size [ROWS];
  logic [31:0]        t_data [ROWS];
  int                 t_mode [ROWS];
  logic [1:0]         t_resp [ROWS];

  ahb_memory_slave dut0 (.*);
  ahb_memory_slave_checker chk0 (.*);

  always
    #10 hclk = ~hclk;

  task automatic add_row(input logic [8*24-1:0] name, input int kind, input logic [31:0] addr,
                         input logic [2:0] size, input logic [31:0] data, input bit rnd,
                         input int mode, input logic [1:0] resp);
    t_name[n] = name;
    t_kind[n] = kind;
    t_addr[n] = addr;
    t_size[n] = size;
    // Rows marked random draw their data here
    t_data[n] = rnd ? $random(seed) : data;
    t_mode[n] = mode;
    t_resp[n] = resp;
    n++;
  endtask

  // Address phase of row r where the mode picks how it is ignored
  task automatic drive_addr(input int r, input logic wr);
    hsel      = (t_mode[r] != 1);
    htrans    = (t_mode[r] == 2) ? HTRANS_IDLE :
                (t_mode[r] == 3) ? HTRANS_BUSY : HTRANS_NONSEQ;
    hready_in = (t_mode[r] != 4);
    hwrite    = wr;
    haddr     = t_addr[r];
    hsize     = t_size[r];
  endtask

  task automatic go_idle();
    hsel      = 1'b0;
    htrans    = HTRANS_IDLE;
    hready_in = 1'b1;
  endtask

  // Ends at the edge that closes the data phase
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge hclk);
    while (hready_out !== 1'b1 && cycles < 20)
    begin
      @(negedge hclk);
      cycles++;
    end
    if (hready_out !== 1'b1)
    begin
      $display("Timeout: the slave never became ready within 20 cycles");
      $display("Finished with errors");
      $finish;
    end
    @(posedge hclk);
    #2;
  endtask

  task automatic run_row(input int r);
    row_name = t_name[r];
    row_resp = t_resp[r];
    drive_addr(r, t_kind[r] != 0);
    @(posedge hclk);
    #2;
    hwdata = t_data[r];
    // Read of the same word right behind the write
    if (t_kind[r] == 2)
    begin
      drive_addr(r, 1'b0);
      wait_ready();
    end
    go_idle();
    wait_ready();
    // One idle cycle closes the test in the checker
    row_done = 1'b1;
    @(posedge hclk);
    #2;
    row_done = 1'b0;
  endtask

  initial
  begin
    hclk     = 1'b0;
    seed     = 32'hbbfcd7ad;
    n        = 0;
    rst_n    = 1'b0;
    hwrite   = 1'b0;
    haddr    = '0;
    hsize    = HSIZE_WORD;
    hwdata   = '0;
    row_name = "reset";
    row_resp = HRESP_OKAY;
    row_done = 1'b0;
    go_idle();
    // Kind 0 read, 1 write, 2 write then read of the same word
    // Mode 0 normal, 1 hsel low, 2 IDLE, 3 BUSY, 4 hready_in low
    add_row("read after reset", 0, 32'h20, HSIZE_WORD, 32'h0, 0, 0, HRESP_OKAY);
    add_row("word write", 1, 32'h10, HSIZE_WORD, 32'hdead_beef, 0, 0, HRESP_OKAY);
    add_row("back to back", 2, 32'h3fc, HSIZE_WORD, 32'h0, 1, 0, HRESP_OKAY);
    add_row("byte write lane 2", 1, 32'h12, HSIZE_BYTE, 32'h11a5_2233, 0, 0, HRESP_OKAY);
    add_row("half write low", 1, 32'h10, HSIZE_HALF, 32'h5566_7788, 0, 0, HRESP_OKAY);
    add_row("merged read", 0, 32'h10, HSIZE_WORD, 32'h0, 0, 0, HRESP_OKAY);
    // All three bad writes alias word 16, so the read below sees any leak
    add_row("misaligned word", 1, 32'h42, HSIZE_WORD, 32'h0, 1, 0, HRESP_ERROR);
    add_row("oversize write", 1, 32'h40, 3'b011, 32'h0, 1, 0, HRESP_ERROR);
    add_row("out of range write", 1, 32'h440, HSIZE_WORD, 32'h0, 1, 0, HRESP_ERROR);
    add_row("read after errors", 0, 32'h40, HSIZE_WORD, 32'h0, 0, 0, HRESP_OKAY);
    add_row("hsel low write", 1, 32'h10, HSIZE_WORD, 32'hffff_ffff, 0, 1, HRESP_OKAY);
    add_row("idle write", 1, 32'h10, HSIZE_WORD, 32'hffff_ffff, 0, 2, HRESP_OKAY);
    add_row("busy write", 1, 32'h10, HSIZE_WORD, 32'hffff_ffff, 0, 3, HRESP_OKAY);
    add_row("hready_in low write", 1, 32'h10, HSIZE_WORD, 32'hffff_ffff, 0, 4, HRESP_OKAY);
    add_row("unchanged read", 0, 32'h10, HSIZE_WORD, 32'h0, 0, 0, HRESP_OKAY);
    repeat (3)
      @(posedge hclk);
    #2;
    rst_n = 1'b1;
    for (int r = 0; r < n; r++)
      run_row(r);
    $display("Tests run: %0d, passed: %0d, failed: %0d", passes + fails, passes, fails);
    if (fails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verilog/ahb_addr_stage.sv ====
// AHB address phase capture with legality check, byte-lane mask and word index
`timescale 1ns/100ps

module ahb_addr_stage (
  input  logic                              hclk,
  input  logic                              rst_n,
  input  logic                              hsel,
  input  logic                              hwrite,
  input  logic                              hready_in,
  input  logic                              ready_own,
  input  logic [ahb_pkg::HADDR_W-1:0]       haddr,
  input  logic [1:0]                        htrans,
  input  logic [2:0]                        hsize,
  output logic                              dp_write,
  output logic                              dp_err,
  output logic [mem_pkg::IDX_W-1:0]         dp_idx,
  output logic [mem_pkg::BYTES_PER_WORD-1:0] dp_lanes
);

  import ahb_pkg::*;
  import mem_pkg::*;

  logic                           active;
  logic                           accept;
  logic                           size_ok;
  logic                           aligned;
  logic                           in_range;
  logic                           legal;
  logic [HADDR_W-OFS_W-1:0]       word_addr;
  logic [BYTES_PER_WORD-1:0]      lanes;

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------
  // Real transfer only for NONSEQ or SEQ
  assign active = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  // Bus must be ready and our own ERROR stall must be over
  assign accept = hsel && active && hready_in && ready_own;

  // ----------------------------------------
  // Legality
  // ----------------------------------------
  // Word address drops the byte offset
  assign word_addr = haddr[HADDR_W-1:OFS_W];
  // Upper address bits must stay inside the array
  assign in_range  = (word_addr < MEM_WORDS);
  assign size_ok   = (hsize <= HSIZE_WORD);

  // Alignment and lane mask both follow size and low address bits
  always_comb
  begin
    case (hsize)
      HSIZE_BYTE:
      begin
        aligned = 1'b1;
        lanes   = 4'b0001 << haddr[OFS_W-1:0];
      end
      HSIZE_HALF:
      begin
        aligned = !haddr[0];
        // Upper or lower halfword
        lanes   = haddr[1] ? 4'b1100 : 4'b0011;
      end
      HSIZE_WORD:
      begin
        aligned = (haddr[OFS_W-1:0] == 2'b00);
        lanes   = 4'b1111;
      end
      default:
      begin
        aligned = 1'b0;
        lanes   = 4'b0000;
      end
    endcase
  end

  assign legal = size_ok && aligned && in_range;

  // ----------------------------------------
  // Data phase registers
  // ----------------------------------------
  always_ff @(posedge hclk)
  begin
    if (!rst_n)
    begin
      dp_write <= 1'b0;
      dp_err   <= 1'b0;
    end
    else if (!ready_own)
    begin
      // First ERROR cycle, flag lasts one cycle
      dp_write <= 1'b0;
      dp_err   <= 1'b0;
    end
    else if (hready_in)
    begin
      dp_write <= accept && legal && hwrite;
      dp_err   <= accept && !legal;
    end
  end

  // Index for reads and writes, lanes for writes only
  always_ff @(posedge hclk)
  begin
    if (accept && legal)
    begin
      dp_idx <= word_addr[IDX_W-1:0];
      if (hwrite)
      begin
        dp_lanes <= lanes;
      end
    end
  end

endmodule

// ==== verilog/ahb_mem_array.sv ====
// Word storage with byte-lane writes in the data phase and a combinational read port
`timescale 1ns/100ps

module ahb_mem_array (
  input  logic                               hclk,
  input  logic                               rst_n,
  input  logic                               dp_write,
  input  logic [mem_pkg::IDX_W-1:0]          dp_idx,
  input  logic [mem_pkg::BYTES_PER_WORD-1:0] dp_lanes,
  input  logic [ahb_pkg::HDATA_W-1:0]        hwdata,
  output logic [ahb_pkg::HDATA_W-1:0]        hrdata
);

  import mem_pkg::*;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  mem_word_u mem [MEM_WORDS];

  // hwdata split into byte lanes
  mem_word_u wr_word;

  assign wr_word.word = hwdata;

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  // Store happens at the edge that ends the data phase
  always_ff @(posedge hclk)
  begin
    if (!rst_n)
    begin
      // Whole array starts at zero
      for (int w = 0; w < MEM_WORDS; w++)
      begin
        mem[w].word <= '0;
      end
    end
    else if (dp_write)
    begin
      // Only enabled lanes change
      for (int l = 0; l < BYTES_PER_WORD; l++)
      begin
        if (dp_lanes[l])
        begin
          mem[dp_idx].lanes[l] <= wr_word.lanes[l];
        end
      end
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  // Always the full word at the data phase index
  // Master picks its own bytes
  assign hrdata = mem[dp_idx].word;

endmodule

// ==== verilog/ahb_memory_slave.sv ====
// AHB memory slave top level connecting address, memory and response stages
`timescale 1ns/100ps

module ahb_memory_slave (
  input  logic                        hclk,
  input  logic                        rst_n,
  input  logic                        hsel,
  input  logic [ahb_pkg::HADDR_W-1:0] haddr,
  input  logic [1:0]                  htrans,
  input  logic                        hwrite,
  input  logic [2:0]                  hsize,
  input  logic [ahb_pkg::HDATA_W-1:0] hwdata,
  input  logic                        hready_in,
  output logic [ahb_pkg::HDATA_W-1:0] hrdata,
  output logic                        hready_out,
  output logic [1:0]                  hresp
);

  import mem_pkg::*;

  // ----------------------------------------
  // Data phase signals
  // ----------------------------------------
  logic                      dp_write;
  logic                      dp_err;
  logic [IDX_W-1:0]          dp_idx;
  logic [BYTES_PER_WORD-1:0] dp_lanes;

  // Address capture and legality check
  // Own hready_out blocks sampling during an ERROR stall
  ahb_addr_stage addr0 (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .hwrite    (hwrite),
    .hready_in (hready_in),
    .ready_own (hready_out),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsize     (hsize),
    .dp_write  (dp_write),
    .dp_err    (dp_err),
    .dp_idx    (dp_idx),
    .dp_lanes  (dp_lanes)
  );

  // Storage with hwdata taken straight from the bus
  ahb_mem_array mem0 (
    .hclk     (hclk),
    .rst_n    (rst_n),
    .dp_write (dp_write),
    .dp_idx   (dp_idx),
    .dp_lanes (dp_lanes),
    .hwdata   (hwdata),
    .hrdata   (hrdata)
  );

  // Response generation
  ahb_resp_stage resp0 (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .dp_err     (dp_err),
    .hready_out (hready_out),
    .hresp      (hresp)
  );

endmodule

// ==== verilog/ahb_pkg.sv ====
// AHB bus widths and the encodings for transfer type, transfer size and slave response
package ahb_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  // ----------------------------------------
  // Transfer type (htrans)
  // ----------------------------------------
  // Only NONSEQ and SEQ carry a transfer
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // ----------------------------------------
  // Transfer size (hsize)
  // ----------------------------------------
  // Anything above a word is illegal for this slave
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // ----------------------------------------
  // Slave response (hresp)
  // ----------------------------------------
  // Split and retry are never given
  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

endpackage

// ==== verilog/ahb_resp_stage.sv ====
// AHB response sequencer for hready_out and hresp with the two-cycle ERROR response
`timescale 1ns/100ps

module ahb_resp_stage (
  input  logic       hclk,
  input  logic       rst_n,
  input  logic       dp_err,
  output logic       hready_out,
  output logic [1:0] hresp
);

  import ahb_pkg::*;

  // ----------------------------------------
  // Sequencer state
  // ----------------------------------------
  // First ERROR cycle is dp_err itself
  // Second ERROR cycle is tracked here
  logic err_second;

  always_ff @(posedge hclk)
  begin
    if (!rst_n)
    begin
      err_second <= 1'b0;
    end
    else
    begin
      // Move to the second cycle right after the first
      err_second <= dp_err;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  // Stall only in the first ERROR cycle
  assign hready_out = !dp_err;

  // ERROR in both cycles of the sequence
  // OKAY otherwise
  assign hresp = (dp_err || err_second) ? HRESP_ERROR : HRESP_OKAY;

endmodule

// ==== verilog/mem_pkg.sv ====
// Memory geometry constants and the memory word type with word and byte-lane views
package mem_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  // Number of words in the array
  localparam int MEM_WORDS = 256;
  // Width of the word index
  localparam int IDX_W = 8;
  // Byte lanes per word
  localparam int BYTES_PER_WORD = 4;
  // Byte offset bits inside a word
  localparam int OFS_W = 2;

  // ----------------------------------------
  // Memory word
  // ----------------------------------------
  // Same 32 bits seen two ways
  // Whole word for reads
  // Separate byte lanes for masked writes
  typedef union packed {
    logic [BYTES_PER_WORD*8-1:0]    word;
    logic [BYTES_PER_WORD-1:0][7:0] lanes;
  } mem_word_u;

endpackage
